// File: flist.f
+incdir+rtl
+incdir+verification
rtl/cpu_pkg.sv
rtl/fetch_if.sv
rtl/exec_if.sv
rtl/program_memory.sv
rtl/control_unit.sv
rtl/cpu_datapath.sv
rtl/tiny_cpu_top.sv
verification/tb_tiny_cpu_top.sv

// File: Bender.yml
package:
  name: tiny_cpu

export_include_dirs:
  - rtl

sources:
  - rtl/cpu_pkg.sv
  - rtl/fetch_if.sv
  - rtl/exec_if.sv
  - rtl/program_memory.sv
  - rtl/control_unit.sv
  - rtl/cpu_datapath.sv
  - rtl/tiny_cpu_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_tiny_cpu_top.sv

// File: verification/tb_cpu_tests.svh
// directed tests for the tiny cpu that the testbench top includes
// each test clears the core, loads its program and runs it from address 0
// an instruction at address k executes on run edge k+1

////////////////////
// host pin helpers
////////////////////

function automatic cpu_pkg::data_t ctrl_word(input logic on, input logic clr,
                                             input logic write, input cpu_pkg::addr_t addr);
  cpu_pkg::data_t w;
  w = '0;
  w[`CPU_UIO_ON_BIT]  = on;
  w[`CPU_UIO_RUN_BIT] = !clr;
  w[`CPU_UIO_MODE_LO] = write;
  w[`CPU_ADDR_W-1:0]  = addr;
  return w;
endfunction

function automatic cpu_pkg::data_t make_instr(input cpu_pkg::opcode_t op,
                                              input cpu_pkg::nibble_t arg);
  return {op, arg};
endfunction

task automatic run_cycles(input int edges);
  uio_in = ctrl_word(1'b1, 1'b0, 1'b0, '0);
  repeat (edges) @(negedge clk);
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
endtask

// runs edge by edge until uo_out shows exp, which must happen on the first edge
task automatic wait_out(input cpu_pkg::data_t exp, input string what);
  int   edges;
  logic seen;
  edges  = 0;
  seen   = 1'b0;
  uio_in = ctrl_word(1'b1, 1'b0, 1'b0, '0);
  while (!seen && edges < OUT_TIMEOUT) begin
    @(negedge clk);
    edges++;
    seen = (uo_out === exp);
  end
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
  check_count++;
  assert (seen && edges == 1) else begin
    if (!seen) begin
      $display("uo_out never showed %s (%h) within %0d cycles", what, exp, OUT_TIMEOUT);
    end else begin
      $display("uo_out showed %s only after %0d cycles instead of 1", what, edges);
    end
    error_count++;
    test_errors++;
  end
endtask

task automatic check_steady(input int edges, input logic on, input cpu_pkg::data_t exp);
  uio_in = ctrl_word(on, 1'b0, 1'b0, '0);
  repeat (edges) begin
    @(negedge clk);
    check_value("uo_out", uo_out, exp);
  end
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
endtask

task automatic clear_core();
  uio_in = ctrl_word(1'b0, 1'b1, 1'b0, '0);
  @(negedge clk);
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
  for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
    program_words[i] = make_instr(cpu_pkg::OP_NOP, '0);
  end
endtask

task automatic load_program();
  for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
    uio_in = ctrl_word(1'b0, 1'b0, 1'b1, cpu_pkg::addr_t'(i));
    ui_in  = program_words[i];
    @(negedge clk);
  end
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
  ui_in  = '0;
endtask

////////////////////
// tests
////////////////////

task automatic test_reset_idle();
  check_value("uo_out", uo_out, '0);
  check_value("uio_out", uio_out, '0);
  check_value("uio_oe", uio_oe, '0);
  // empty memory is all NOPs
  check_steady(20, 1'b1, '0);
  end_test("reset_idle");
endtask

task automatic test_immediate_out();
  cpu_pkg::data_t a;
  cpu_pkg::data_t b;
  cpu_pkg::data_t c;
  next_byte(a);
  next_byte(b);
  next_byte(c);
  clear_core();
  program_words[0] = make_instr(cpu_pkg::OP_LDA_LO, a[3:0]);
  program_words[1] = make_instr(cpu_pkg::OP_LDA_HI, a[7:4]);
  program_words[2] = make_instr(cpu_pkg::OP_LDB_LO, b[3:0]);
  program_words[3] = make_instr(cpu_pkg::OP_LDB_HI, b[7:4]);
  program_words[4] = make_instr(cpu_pkg::OP_LDC_LO, c[3:0]);
  program_words[5] = make_instr(cpu_pkg::OP_LDC_HI, c[7:4]);
  program_words[6] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  program_words[7] = make_instr(cpu_pkg::OP_OUT, 4'd1);
  program_words[8] = make_instr(cpu_pkg::OP_OUT, 4'd2);
  // operand 3 selects no register
  program_words[9] = make_instr(cpu_pkg::OP_OUT, 4'd3);
  load_program();
  run_cycles(6);
  check_value("uo_out", uo_out, '0);
  wait_out(a, "register A");
  wait_out(b, "register B");
  wait_out(c, "register C");
  run_cycles(1);
  check_value("uo_out", uo_out, c);
  end_test("immediate_out");
endtask

task automatic test_alu();
  cpu_pkg::data_t a;
  cpu_pkg::data_t b;
  cpu_pkg::data_t sum;
  cpu_pkg::data_t diff;
  cpu_pkg::data_t prod;
  for (int k = 0; k < 4; k++) begin
    if (k == 0) begin
      // sum, difference and product all wrap
      a = 8'h20;
      b = 8'hF0;
    end else begin
      next_byte(a);
      next_byte(b);
    end
    // integer results reduced modulo 256
    sum  = cpu_pkg::data_t'((int'(a) + int'(b)) % 256);
    diff = cpu_pkg::data_t'((int'(a) - int'(b) + 256) % 256);
    prod = cpu_pkg::data_t'((int'(a) * int'(b)) % 256);
    clear_core();
    program_words[0] = make_instr(cpu_pkg::OP_IN, 4'd0);
    program_words[1] = make_instr(cpu_pkg::OP_IN, 4'd1);
    program_words[2] = make_instr(cpu_pkg::OP_ADD, '0);
    program_words[3] = make_instr(cpu_pkg::OP_OUT, 4'd2);
    program_words[4] = make_instr(cpu_pkg::OP_SUB, '0);
    program_words[5] = make_instr(cpu_pkg::OP_OUT, 4'd2);
    program_words[6] = make_instr(cpu_pkg::OP_MUL, '0);
    program_words[7] = make_instr(cpu_pkg::OP_OUT, 4'd2);
    load_program();
    ui_in = a;
    run_cycles(1);
    ui_in = b;
    run_cycles(1);
    ui_in = '0;
    run_cycles(1);
    wait_out(sum, "A+B");
    run_cycles(1);
    wait_out(diff, "A-B");
    run_cycles(1);
    wait_out(prod, "A*B");
  end
  end_test("alu");
endtask

task automatic test_halt();
  clear_core();
  program_words[0] = make_instr(cpu_pkg::OP_LDA_LO, 4'h5);
  program_words[1] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  program_words[2] = make_instr(cpu_pkg::OP_LDA_LO, 4'h9);
  program_words[3] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  program_words[4] = make_instr(cpu_pkg::OP_LDA_HI, 4'h3);
  program_words[5] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  load_program();
  run_cycles(1);
  wait_out(8'h05, "first output");
  check_steady(10, 1'b0, 8'h05);
  // a restart from 0 would show 05 again
  run_cycles(1);
  wait_out(8'h09, "output after resume");
  // the host tries to write address 5 while the core runs address 4
  uio_in = ctrl_word(1'b1, 1'b0, 1'b1, 4'd5);
  ui_in  = make_instr(cpu_pkg::OP_OUT, 4'd3);
  @(negedge clk);
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
  ui_in  = '0;
  wait_out(8'h39, "original word at address 5");
  end_test("halt");
endtask

task automatic test_clear();
  clear_core();
  program_words[0] = make_instr(cpu_pkg::OP_LDA_LO, 4'hF);
  program_words[1] = make_instr(cpu_pkg::OP_LDA_HI, 4'hA);
  program_words[2] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  load_program();
  run_cycles(2);
  wait_out(8'hAF, "output before clear");
  // clear wins over run
  uio_in = ctrl_word(1'b1, 1'b1, 1'b0, '0);
  @(negedge clk);
  uio_in = ctrl_word(1'b0, 1'b0, 1'b0, '0);
  check_value("uo_out", uo_out, '0);
  check_steady(20, 1'b1, '0);
  // wiped registers read back as 0 through OUT
  program_words[0] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  program_words[1] = make_instr(cpu_pkg::OP_OUT, 4'd1);
  program_words[2] = make_instr(cpu_pkg::OP_OUT, 4'd2);
  load_program();
  check_steady(`CPU_RAM_DEPTH, 1'b1, '0);
  end_test("clear");
endtask

task automatic test_wrap();
  cpu_pkg::data_t a;
  cpu_pkg::data_t b;
  next_byte(a);
  b = ~a;
  clear_core();
  program_words[0]  = make_instr(cpu_pkg::OP_LDA_LO, a[3:0]);
  program_words[1]  = make_instr(cpu_pkg::OP_LDA_HI, a[7:4]);
  program_words[2]  = make_instr(cpu_pkg::OP_LDB_LO, b[3:0]);
  program_words[3]  = make_instr(cpu_pkg::OP_LDB_HI, b[7:4]);
  program_words[4]  = make_instr(cpu_pkg::OP_OUT, 4'd1);
  program_words[15] = make_instr(cpu_pkg::OP_OUT, 4'd0);
  load_program();
  run_cycles(4);
  wait_out(b, "B on the first pass");
  run_cycles(10);
  wait_out(a, "A from the last word");
  run_cycles(4);
  check_value("uo_out", uo_out, a);
  wait_out(b, "B on the second pass");
  run_cycles(10);
  check_value("uo_out", uo_out, b);
  wait_out(a, "A after the wrap");
  end_test("wrap");
endtask

// File: verification/tb_tiny_cpu_top.sv
// testbench top for the tiny cpu
// inputs change on the falling clock edge and outputs are sampled there
// uio_in idles at halted with clear released, the tests sit in tb_cpu_tests.svh
// a watchdog ends the run if a test never returns

`include "cpu_params.svh"

module tb_tiny_cpu_top;

  localparam int OUT_TIMEOUT = 8;
  localparam int SIM_LIMIT   = 200000;

  logic           clk;
  logic           arst_n;
  logic           ena;
  cpu_pkg::data_t ui_in;
  cpu_pkg::data_t uio_in;
  cpu_pkg::data_t uo_out;
  cpu_pkg::data_t uio_out;
  cpu_pkg::data_t uio_oe;

  int             error_count;
  int             check_count;
  int             test_errors;
  int             test_count;
  logic [7:0]     lfsr_state;
  cpu_pkg::data_t program_words [`CPU_RAM_DEPTH];

  tiny_cpu_top dut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // random bytes
  ////////////////////

  // galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 8'hB8;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  task automatic next_byte(output cpu_pkg::data_t value);
    for (int i = 0; i < `CPU_DATA_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value[i]   = lfsr_state[0];
    end
  endtask

  ////////////////////
  // checking
  ////////////////////

  task automatic check_value(input string name, input cpu_pkg::data_t got,
                             input cpu_pkg::data_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  `include "tb_cpu_tests.svh"

  // watchdog
  initial begin
    #(SIM_LIMIT);
    $display("simulation stopped, the tests did not finish within %0d time units", SIM_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    error_count = 0;
    check_count = 0;
    test_errors = 0;
    test_count  = 0;
    lfsr_state  = 8'd61;
    arst_n      = 1'b0;
    ena         = 1'b1;
    ui_in       = '0;
    uio_in      = ctrl_word(1'b0, 1'b0, 1'b0, '0);
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    test_reset_idle();
    test_immediate_out();
    test_alu();
    test_halt();
    test_clear();
    test_wrap();

    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: rtl/tiny_cpu_top.sv
// pin level top of the tiny cpu
// ui_in is both the program write data and the IN source
// uio pins are inputs only, uio_out and uio_oe stay at 0
// ena is not used, the core is controlled through uio_in alone

module tiny_cpu_top (
  input  cpu_pkg::data_t ui_in,
  output cpu_pkg::data_t uo_out,
  input  cpu_pkg::data_t uio_in,
  output cpu_pkg::data_t uio_out,
  output cpu_pkg::data_t uio_oe,
  input  logic           ena,
  input  logic           clk,
  input  logic           arst_n
);

  ////////////////////
  // internal buses
  ////////////////////

  fetch_if fetch_bus ();
  exec_if  exec_bus ();

  ////////////////////
  // fetch and memory
  ////////////////////

  program_memory u_program_memory (
    .clk    (clk),
    .arst_n (arst_n),
    .wdata  (ui_in),
    .fetch  (fetch_bus.mem)
  );

  ////////////////////
  // control
  ////////////////////

  control_unit u_control_unit (
    .host_ctrl (uio_in),
    .fetch     (fetch_bus.ctrl),
    .exec      (exec_bus.ctrl)
  );

  ////////////////////
  // registers and alu
  ////////////////////

  cpu_datapath u_cpu_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  (ui_in),
    .exec     (exec_bus.dp),
    .out_data (uo_out)
  );

  // bidirectional pins are always inputs
  assign uio_out = '0;
  assign uio_oe  = '0;

endmodule

// File: rtl/cpu_datapath.sv
// registers A, B, C, the alu and the output register
// every result is registered on the edge that executes it
// alu results are kept modulo 256, no carry or flags
// a register select of REG_NONE writes and outputs nothing

`include "cpu_params.svh"

module cpu_datapath (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::data_t in_data,
  exec_if.dp             exec,
  output cpu_pkg::data_t out_data
);

  cpu_pkg::data_t reg_a;
  cpu_pkg::data_t reg_b;
  cpu_pkg::data_t reg_c;
  cpu_pkg::data_t out_q;

  cpu_pkg::data_t sel_value;
  cpu_pkg::data_t wr_data;
  logic           wr_en;
  logic           out_en;

  ////////////////////
  // operand select
  ////////////////////

  always_comb begin
    case (exec.sel)
      cpu_pkg::REG_A: sel_value = reg_a;
      cpu_pkg::REG_B: sel_value = reg_b;
      cpu_pkg::REG_C: sel_value = reg_c;
      default:        sel_value = '0;
    endcase
  end

  ////////////////////
  // alu and write data
  ////////////////////

  always_comb begin
    wr_en   = 1'b0;
    wr_data = '0;
    case (exec.op)
      // nibble loads keep the other half of the register
      cpu_pkg::EX_LOAD_LO: begin
        wr_en   = 1'b1;
        wr_data = {sel_value[`CPU_DATA_W-1:`CPU_NIBBLE_W], exec.imm};
      end
      cpu_pkg::EX_LOAD_HI: begin
        wr_en   = 1'b1;
        wr_data = {exec.imm, sel_value[`CPU_NIBBLE_W-1:0]};
      end
      cpu_pkg::EX_ADD: begin
        wr_en   = 1'b1;
        wr_data = reg_a + reg_b;
      end
      cpu_pkg::EX_SUB: begin
        wr_en   = 1'b1;
        wr_data = reg_a - reg_b;
      end
      // 8 bit context keeps only the low byte of the product
      cpu_pkg::EX_MUL: begin
        wr_en   = 1'b1;
        wr_data = reg_a * reg_b;
      end
      cpu_pkg::EX_IN: begin
        wr_en   = 1'b1;
        wr_data = in_data;
      end
      default: ;
    endcase
  end

  assign out_en = (exec.op == cpu_pkg::EX_OUT) && (exec.sel != cpu_pkg::REG_NONE);

  ////////////////////
  // register file
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
      out_q <= '0;
    end else if (exec.clear) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
      out_q <= '0;
    end else begin
      if (wr_en) begin
        case (exec.sel)
          cpu_pkg::REG_A: reg_a <= wr_data;
          cpu_pkg::REG_B: reg_b <= wr_data;
          cpu_pkg::REG_C: reg_c <= wr_data;
          default: ;
        endcase
      end
      if (out_en) begin
        out_q <= sel_value;
      end
    end
  end

  assign out_data = out_q;

endmodule

// File: rtl/control_unit.sv
// host pin and instruction decode, purely combinational
// clear (uio_in[6] low) wins over run, host write and execute
// IN and OUT take their register from the operand nibble,
// operand values above 2 select no register

`include "cpu_params.svh"

module control_unit (
  input  cpu_pkg::data_t host_ctrl,
  fetch_if.ctrl          fetch,
  exec_if.ctrl           exec
);

  ////////////////////
  // host control fields
  ////////////////////

  logic       on_req;
  logic       clear_req;
  logic [1:0] mode;
  logic       run;

  assign on_req    = host_ctrl[`CPU_UIO_ON_BIT];
  assign clear_req = !host_ctrl[`CPU_UIO_RUN_BIT];
  assign mode      = {host_ctrl[`CPU_UIO_MODE_HI], host_ctrl[`CPU_UIO_MODE_LO]};
  assign run       = on_req && !clear_req;

  assign fetch.clear     = clear_req;
  assign exec.clear      = clear_req;
  assign fetch.advance   = run;
  // mode 01 is a host write, only honoured while halted
  assign fetch.load_en   = !on_req && !clear_req && (mode == 2'b01);
  assign fetch.load_addr = host_ctrl[`CPU_ADDR_W-1:0];

  ////////////////////
  // instruction decode
  ////////////////////

  cpu_pkg::opcode_t  opcode;
  cpu_pkg::nibble_t  operand;
  cpu_pkg::reg_sel_t operand_sel;

  assign opcode   = cpu_pkg::opcode_t'(fetch.instr[`CPU_DATA_W-1:`CPU_NIBBLE_W]);
  assign operand  = fetch.instr[`CPU_NIBBLE_W-1:0];
  assign exec.imm = operand;

  // register named by the operand of IN and OUT
  always_comb begin
    case (operand)
      4'd0:    operand_sel = cpu_pkg::REG_A;
      4'd1:    operand_sel = cpu_pkg::REG_B;
      4'd2:    operand_sel = cpu_pkg::REG_C;
      default: operand_sel = cpu_pkg::REG_NONE;
    endcase
  end

  always_comb begin
    exec.op  = cpu_pkg::EX_NONE;
    exec.sel = cpu_pkg::REG_NONE;
    if (run) begin
      case (opcode)
        cpu_pkg::OP_LDA_LO: begin
          exec.op  = cpu_pkg::EX_LOAD_LO;
          exec.sel = cpu_pkg::REG_A;
        end
        cpu_pkg::OP_LDA_HI: begin
          exec.op  = cpu_pkg::EX_LOAD_HI;
          exec.sel = cpu_pkg::REG_A;
        end
        cpu_pkg::OP_LDB_LO: begin
          exec.op  = cpu_pkg::EX_LOAD_LO;
          exec.sel = cpu_pkg::REG_B;
        end
        cpu_pkg::OP_LDB_HI: begin
          exec.op  = cpu_pkg::EX_LOAD_HI;
          exec.sel = cpu_pkg::REG_B;
        end
        cpu_pkg::OP_LDC_LO: begin
          exec.op  = cpu_pkg::EX_LOAD_LO;
          exec.sel = cpu_pkg::REG_C;
        end
        cpu_pkg::OP_LDC_HI: begin
          exec.op  = cpu_pkg::EX_LOAD_HI;
          exec.sel = cpu_pkg::REG_C;
        end
        // alu results always land in C
        cpu_pkg::OP_ADD: begin
          exec.op  = cpu_pkg::EX_ADD;
          exec.sel = cpu_pkg::REG_C;
        end
        cpu_pkg::OP_SUB: begin
          exec.op  = cpu_pkg::EX_SUB;
          exec.sel = cpu_pkg::REG_C;
        end
        cpu_pkg::OP_MUL: begin
          exec.op  = cpu_pkg::EX_MUL;
          exec.sel = cpu_pkg::REG_C;
        end
        cpu_pkg::OP_OUT: begin
          exec.op  = cpu_pkg::EX_OUT;
          exec.sel = operand_sel;
        end
        cpu_pkg::OP_IN: begin
          exec.op  = cpu_pkg::EX_IN;
          exec.sel = operand_sel;
        end
        // NOP and the unused codes 12 to 15
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/program_memory.sv
// 16 word program store with its program counter
// read is combinational, writes, clears and steps take one edge
// the counter wraps from the last address back to 0
// host writes are only issued by the control unit while halted

`include "cpu_params.svh"

module program_memory (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::data_t wdata,
  fetch_if.mem           fetch
);

  ////////////////////
  // storage
  ////////////////////

  cpu_pkg::data_t mem [`CPU_RAM_DEPTH];
  cpu_pkg::addr_t pc;

  // instruction fetch
  assign fetch.instr = mem[pc];

  ////////////////////
  // program counter
  ////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (fetch.clear) begin
      pc <= '0;
    end else if (!fetch.load_en && fetch.advance) begin
      // natural overflow gives the 15 -> 0 wrap
      pc <= pc + cpu_pkg::addr_t'(1);
    end
  end

  ////////////////////
  // memory words
  ////////////////////

  // the clear pin must wipe the whole program, so every word is reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem <= '{default: '0};
    end else if (fetch.clear) begin
      mem <= '{default: '0};
    end else if (fetch.load_en) begin
      mem[fetch.load_addr] <= wdata;
    end
  end

endmodule

// File: rtl/exec_if.sv
// execute commands from the control unit to the datapath
// op is EX_NONE whenever the core is halted or clearing

interface exec_if;

  cpu_pkg::exec_op_t op;

  // destination for loads and IN, source for OUT
  cpu_pkg::reg_sel_t sel;

  cpu_pkg::nibble_t imm;

  // synchronous wipe of registers and output
  logic clear;

  modport ctrl (
    output op,
    output sel,
    output imm,
    output clear
  );

  modport dp (
    input op,
    input sel,
    input imm,
    input clear
  );

endinterface

// File: rtl/fetch_if.sv
// link between the control unit and the program memory
// all signals are plain levels sampled on the rising clock edge
// advance and load_en are never high together

interface fetch_if;

  // word at the current program counter
  cpu_pkg::data_t instr;

  // step the counter on this edge
  logic advance;

  // host write of ui_in at load_addr
  logic           load_en;
  cpu_pkg::addr_t load_addr;

  // zero the counter and every memory word
  logic clear;

  modport ctrl (
    input  instr,
    output advance,
    output load_en,
    output load_addr,
    output clear
  );

  modport mem (
    output instr,
    input  advance,
    input  load_en,
    input  load_addr,
    input  clear
  );

endinterface

// File: rtl/cpu_pkg.sv
// shared types of the tiny cpu
// opcodes live in the upper nibble of an instruction word
// codes 12 to 15 are not named and decode as no-ops

`include "cpu_params.svh"

package cpu_pkg;

  ////////////////////
  // vector types
  ////////////////////

  typedef logic [`CPU_DATA_W-1:0]   data_t;
  typedef logic [`CPU_ADDR_W-1:0]   addr_t;
  typedef logic [`CPU_NIBBLE_W-1:0] nibble_t;

  ////////////////////
  // instruction set
  ////////////////////

  typedef enum logic [3:0] {
    OP_NOP    = 4'd0,
    OP_LDA_LO = 4'd1,
    OP_LDA_HI = 4'd2,
    OP_LDB_LO = 4'd3,
    OP_LDB_HI = 4'd4,
    OP_LDC_LO = 4'd5,
    OP_LDC_HI = 4'd6,
    OP_ADD    = 4'd7,
    OP_SUB    = 4'd8,
    OP_MUL    = 4'd9,
    OP_OUT    = 4'd10,
    OP_IN     = 4'd11
  } opcode_t;

  // REG_NONE turns IN and OUT into no-ops
  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_t;

  // operations handed from the control unit to the datapath
  typedef enum logic [2:0] {
    EX_NONE    = 3'd0,
    EX_LOAD_LO = 3'd1,
    EX_LOAD_HI = 3'd2,
    EX_ADD     = 3'd3,
    EX_SUB     = 3'd4,
    EX_MUL     = 3'd5,
    EX_OUT     = 3'd6,
    EX_IN      = 3'd7
  } exec_op_t;

endpackage

// File: rtl/cpu_params.svh
// widths, program depth and host pin map of the tiny cpu
// the uio_in bit positions must match what the host drives
// the mode field value 01 requests a host write, other values are idle

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////
// datapath widths
////////////////////

`define CPU_DATA_W      8
`define CPU_ADDR_W      4
`define CPU_NIBBLE_W    4

// one word per address, so depth is 2**CPU_ADDR_W
`define CPU_RAM_DEPTH   16

////////////////////
// uio_in control bits
////////////////////

// high runs the core
`define CPU_UIO_ON_BIT  7
// low requests a clear of all state
`define CPU_UIO_RUN_BIT 6
// mode field, 01 writes ui_in to memory while halted
`define CPU_UIO_MODE_HI 5
`define CPU_UIO_MODE_LO 4

`endif
